//--- src.f
+incdir+.
vga_pkg.sv
frame_if.sv
raster_capture.sv
line_buffer.sv
scan_timing.sv
vga_sync_top.sv
vga_sync_checker.sv
tb_clock_gen.sv
tb_vga_sync.sv

//--- Makefile
TOP := tb_vga_sync

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f src.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

//--- tb_vga_sync.sv
`timescale 1ns/1ps
`include "vga_defs.svh"

module tb_vga_sync;
    import vga_pkg::*;

    localparam int NUM_PHASES = 4;
    localparam int FRAME_PAL  = 4 * (`MAX_W_PAL + 1) * (`MAX_H_PAL + 1);
    localparam int FRAME_R8   = 4 * (`MAX_W_R8 + 1) * (`MAX_H_R8 + 1);
    // two pal native, two pal doubled, two r8 native and one r8 csync frame, plus a tenth
    localparam int TIMEOUT    = (4 * FRAME_PAL + 3 * FRAME_R8) * 11 / 10;

    logic       clk_dot4x, rst;
    logic [3:0] dot_rising;
    logic       is_native_x_in, is_native_y_in;
    logic       hpolarity, vpolarity, enable_csync;
    chip_t      chip;
    raster_x_t  raster_x;
    raster_y_t  raster_y;
    color_t     pixel_color;
    logic       hsync, vsync, active, half_bright;
    color_t     pixel_color_out;

    int phase_frames [NUM_PHASES] = '{2, 2, 2, 1};
    int phase, frames_in_phase, cycles;
    logic running, run_done;

    // expected values for the current phase, taken from the timing tables
    int raster_max_w, raster_max_h;
    int exp_line_cycles, exp_hs_width, exp_frame_lines, exp_vs_line, exp_active_lines;

    // raster source state
    color_t line_offset, done_color;

    // measurement state
    logic   hs_prev, vs_prev, act_prev, hs_act, vs_act, vs_rise, hb_prev, exp_hb;
    logic   csync_wide;
    int     last_rise, width, hs_rises, vsyncs_seen, active_lines, frame_lines, line_idx;
    int     swaps, swap_age;
    color_t exp_color;
    int     width_checks, period_checks, frame_checks, hb_checks, pixel_checks;
    int     err_hsync, err_frame, err_half, err_pixel, err_other;

    tb_clock_gen u_clock (
        .clk_dot4x (clk_dot4x),
        .rst       (rst)
    );

    vga_sync_top UUT (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .dot_rising      (dot_rising),
        .is_native_y_in  (is_native_y_in),
        .is_native_x_in  (is_native_x_in),
        .hpolarity       (hpolarity),
        .vpolarity       (vpolarity),
        .enable_csync    (enable_csync),
        .chip            (chip),
        .raster_x        (raster_x),
        .raster_y        (raster_y),
        .pixel_color     (pixel_color),
        .hsync           (hsync),
        .vsync           (vsync),
        .active          (active),
        .pixel_color_out (pixel_color_out),
        .half_bright     (half_bright)
    );

    // load mode inputs and the expected timing for one phase
    task automatic set_phase(input int p);
        logic pal;
        int   mult;
        int   nat_w;
        int   nat_h;
        chip           = (p < 2) ? `CHIP6569R3 : `CHIP6567R8;
        is_native_x_in = (p != 1);
        is_native_y_in = (p != 1);
        enable_csync   = (p == 3);
        hpolarity      = (p != 3);              // csync phase runs active low
        vpolarity      = (p != 3);
        pal   = chip[0];
        mult  = is_native_x_in ? 1 : 2;
        nat_w = pal ? `MAX_W_PAL : `MAX_W_R8;
        nat_h = pal ? `MAX_H_PAL : `MAX_H_R8;
        raster_max_w     = nat_w;
        raster_max_h     = nat_h;
        exp_line_cycles  = is_native_x_in ? 4 * (nat_w + 1) : 2 * (nat_w + 1);
        exp_hs_width     = is_native_x_in ? 4 * (`HS_END - `HS_STA + 1)
                                          : 2 * (`HS_END - `HS_STA) + 1;
        exp_frame_lines  = (nat_h + 1) * mult;
        exp_vs_line      = (pal ? `VS_STA_PAL : `VS_STA_NTSC) * mult;
        exp_active_lines = pal ? (`VA_STA_PAL - `VA_END_PAL) * mult
                               : exp_frame_lines - (`VA_STA_NTSC - `VA_END_NTSC) * mult;
        hs_rises    = 0;                         // measurements restart with the mode
        vsyncs_seen = 0;
        swaps       = 0;
    endtask

    // raster source, one dot every four clocks, one colour per line
    initial begin
        void'($urandom(32'h05358368));
        dot_rising  = 4'b0001;
        raster_x    = '0;
        raster_y    = '0;
        line_offset = '0;
        pixel_color = '0;
        done_color  = '0;
        phase       = 0;
        frames_in_phase = 0;
        run_done    = 1'b0;
        set_phase(0);
        forever begin
            @(negedge clk_dot4x);
            if (running && !run_done) begin
                dot_rising = {dot_rising[2:0], dot_rising[3]};
                if (dot_rising[0]) begin                 // next dot
                    if (raster_x == raster_x_t'(raster_max_w)) begin
                        raster_x   = '0;
                        done_color = pixel_color;        // line that just finished
                        if (raster_y == raster_y_t'(raster_max_h)) begin
                            raster_y = '0;
                            frames_in_phase++;
                            if (frames_in_phase == phase_frames[phase]) begin
                                frames_in_phase = 0;
                                phase++;
                                if (phase == NUM_PHASES) run_done = 1'b1;
                                else set_phase(phase);   // lands on the frame origin
                            end
                        end else begin
                            raster_y = raster_y + 1'b1;
                        end
                        if ($urandom_range(7) == 0) line_offset = color_t'($urandom_range(15));
                        pixel_color = raster_y[3:0] + line_offset;
                    end else begin
                        raster_x = raster_x + 1'b1;
                    end
                end
            end
        end
    end

    initial begin
        {hs_prev, vs_prev, act_prev, hb_prev, csync_wide} = '0;
        {last_rise, line_idx, active_lines, frame_lines, swap_age} = '0;
        {width_checks, period_checks, frame_checks, hb_checks, pixel_checks} = '0;
        {err_hsync, err_frame, err_half, err_pixel, err_other} = '0;
        exp_color = '0;
    end

    always @(posedge clk_dot4x) begin
        cycles  <= rst ? 0 : cycles + 1;
        running <= !rst;
        if (!rst) begin
            hs_act  = (hsync == hpolarity);
            vs_act  = !enable_csync && (vsync == vpolarity);
            vs_rise = vs_act && !vs_prev;
            if (vs_rise) begin                           // one frame between vsync starts
                if (vsyncs_seen >= 1) begin
                    frame_checks++;
                    assert (active_lines == exp_active_lines) else begin
                        err_frame++;
                        $display("mismatch active lines: got %h expected %h",
                                 active_lines, exp_active_lines);
                    end
                    assert (frame_lines == exp_frame_lines) else begin
                        err_frame++;
                        $display("mismatch lines per frame: got %h expected %h",
                                 frame_lines, exp_frame_lines);
                    end
                end
                vsyncs_seen++;
                active_lines = 0;
                frame_lines  = 0;
            end
            if (active && !act_prev) active_lines++;     // one rise per active line
            if (hs_act && !hs_prev) begin
                frame_lines++;
                hs_rises++;
                line_idx = vs_rise ? exp_vs_line : (line_idx + 1) % exp_frame_lines;
                if (vsyncs_seen >= 1) begin
                    period_checks++;
                    assert (cycles - last_rise == exp_line_cycles) else begin
                        err_hsync++;
                        $display("mismatch hsync period: got %h expected %h",
                                 cycles - last_rise, exp_line_cycles);
                    end
                    exp_hb = (line_idx == 0) ? 1'b0 : ~hb_prev;  // line 0 always bright
                    hb_checks++;
                    assert (half_bright == exp_hb) else begin
                        err_half++;
                        $display("mismatch half_bright: got %h expected %h", half_bright, exp_hb);
                    end
                end
                last_rise = cycles;
                hb_prev   = half_bright;
            end
            if (!hs_act && hs_prev && hs_rises > 0) begin
                width = cycles - last_rise;
                if (enable_csync) begin
                    if (width > exp_line_cycles) csync_wide = 1'b1;   // vsync lines merged
                end else if (vsyncs_seen >= 1) begin
                    width_checks++;
                    assert (width == exp_hs_width) else begin
                        err_hsync++;
                        $display("mismatch hsync width: got %h expected %h", width, exp_hs_width);
                    end
                end
            end
            // bank swap on phase 1 of column 0, read side shows the finished line
            if (dot_rising[1] && raster_x == '0) begin
                exp_color = done_color;
                swap_age  = 0;
                swaps++;
            end else if (swap_age < 3) begin
                swap_age++;
            end
            if (active && is_native_x_in && swaps >= 2 && swap_age >= 3) begin
                pixel_checks++;
                assert (pixel_color_out == exp_color) else begin
                    err_pixel++;
                    $display("mismatch pixel_color_out: got %h expected %h",
                             pixel_color_out, exp_color);
                end
            end
            hs_prev  = hs_act;
            vs_prev  = vs_act;
            act_prev = active;
        end
    end

    initial begin
        wait (rst == 1'b0);
        while (!run_done && cycles < TIMEOUT) @(posedge clk_dot4x);
        if (!run_done) begin
            err_other++;
            $display("timeout: raster phases not finished after %0d cycles", cycles);
        end else begin
            if (!csync_wide) begin
                err_other++;
                $display("composite sync never widened hsync over the vsync lines");
            end
            if (width_checks == 0 || period_checks == 0 || frame_checks == 0
                || hb_checks == 0 || pixel_checks == 0) begin
                err_other++;
                $display("some timing or pixel checks were never reached");
            end
        end
        $display("errors: hsync=%0d frame=%0d half_bright=%0d pixel=%0d other=%0d",
                 err_hsync, err_frame, err_half, err_pixel, err_other);
        if (err_hsync + err_frame + err_half + err_pixel + err_other == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

// free running dot4x clock and a short power-on reset
module tb_clock_gen (
    output logic clk_dot4x,
    output logic rst
);

    localparam realtime HALF_PERIOD = 50ns;   // 100 ns period

    initial begin
        clk_dot4x = 1'b0;
        forever #(HALF_PERIOD) clk_dot4x = ~clk_dot4x;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk_dot4x);      // two full cycles in reset
        @(negedge clk_dot4x);
        rst = 1'b0;                            // released away from the sampling edge
    end

endmodule

//--- vga_sync_checker.sv
`timescale 1ns/1ps

// protocol checks on the top level outputs, attached with bind
module vga_sync_checker (
    input logic            clk_dot4x,
    input logic            rst,
    input logic            hsync,
    input logic            vsync,
    input logic            active,
    input logic            half_bright,
    input logic            enable_csync,
    input vga_pkg::color_t pixel_color_out
);

    // reset leaves the output register and the dimming flag cleared
    a_reset_clears : assert property (@(posedge clk_dot4x)
        rst |=> (half_bright == 1'b0 && pixel_color_out == '0))
        else $error("reset did not clear half_bright or pixel_color_out");

    // sync and blanking come from counters that are always reset
    a_no_unknown : assert property (@(posedge clk_dot4x) disable iff (rst)
        !$isunknown({hsync, vsync, active, half_bright}))
        else $error("sync or blanking output is unknown after reset");

    // composite sync moves vertical sync onto hsync, vsync sits low
    a_csync_vsync_low : assert property (@(posedge clk_dot4x) disable iff (rst)
        enable_csync |-> (vsync == 1'b0))
        else $error("vsync pulsed while composite sync was enabled");

endmodule

bind vga_sync_top vga_sync_checker u_checker (.*);

//--- vga_sync_top.sv
`timescale 1ns/1ps
`include "vga_defs.svh"

// line-doubling scan converter top
module vga_sync_top (
    input  logic               clk_dot4x,
    input  logic               rst,
    input  logic [3:0]         dot_rising,
    input  logic               is_native_y_in,
    input  logic               is_native_x_in,
    input  logic               hpolarity,
    input  logic               vpolarity,
    input  logic               enable_csync,
    input  vga_pkg::chip_t     chip,
    input  vga_pkg::raster_x_t raster_x,        // native res counters
    input  vga_pkg::raster_y_t raster_y,
    input  vga_pkg::color_t    pixel_color,
    output logic               hsync,
    output logic               vsync,
    output logic               active,
    output vga_pkg::color_t    pixel_color_out,
    output logic               half_bright
);
    import vga_pkg::*;

    raster_x_t wr_addr;
    color_t    wr_color;
    logic      swap;
    hpos_t     rd_addr;

    frame_if frame ();

    raster_capture u_capture (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .dot_rising     (dot_rising),
        .raster_x       (raster_x),
        .raster_y       (raster_y),
        .pixel_color    (pixel_color),
        .is_native_x_in (is_native_x_in),
        .is_native_y_in (is_native_y_in),
        .chip           (chip),
        .wr_addr        (wr_addr),
        .wr_color       (wr_color),
        .swap           (swap),
        .frame          (frame.capture)
    );

    line_buffer u_line_buffer (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .swap            (swap),
        .wr_addr         (wr_addr),
        .wr_color        (wr_color),
        .rd_addr         (rd_addr),
        .pixel_color_out (pixel_color_out)
    );

    scan_timing u_scan_timing (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .frame        (frame.timing),
        .hpolarity    (hpolarity),
        .vpolarity    (vpolarity),
        .enable_csync (enable_csync),
        .rd_addr      (rd_addr),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active),
        .half_bright  (half_bright)
    );

endmodule

//--- scan_timing.sv
`timescale 1ns/1ps
`include "vga_defs.svh"

module scan_timing (
    input  logic           clk_dot4x,
    input  logic           rst,
    frame_if.timing        frame,
    input  logic           hpolarity,     // 1 = active high hsync
    input  logic           vpolarity,     // 1 = active high vsync
    input  logic           enable_csync,  // composite sync on hsync
    output vga_pkg::hpos_t rd_addr,
    output logic           hsync,
    output logic           vsync,
    output logic           active,
    output logic           half_bright
);
    import vga_pkg::*;

    hpos_t      h_count;       // output x
    vpos_t      v_count;       // output y
    logic [1:0] phase;         // free running dot4x divider
    logic       advance;

    // native table values for the latched chip
    hpos_t nat_ha_sta;
    hpos_t nat_max_w;
    vpos_t nat_va_end;
    vpos_t nat_va_sta;
    vpos_t nat_vs_sta;
    vpos_t nat_vs_end;
    vpos_t nat_max_h;

    // boundaries after doubling
    hpos_t ha_end, ha_sta, hs_sta, hs_end, max_w;
    vpos_t va_end, va_sta, vs_sta, vs_end, max_h;

    logic hsync_ah, vsync_ah, csync_ah;
    logic vactive;

    function automatic hpos_t scale_h(input hpos_t v, input logic native);
        return native ? v : hpos_t'(v << 1);
    endfunction

    function automatic vpos_t scale_v(input vpos_t v, input logic native);
        return native ? v : vpos_t'(v << 1);
    endfunction

    always_comb begin
        // ntsc r56a unless the case below says otherwise
        nat_ha_sta = hpos_t'(`HA_STA_NTSC);
        nat_max_w  = hpos_t'(`MAX_W_R56A);
        nat_va_end = vpos_t'(`VA_END_NTSC);
        nat_va_sta = vpos_t'(`VA_STA_NTSC);
        nat_vs_sta = vpos_t'(`VS_STA_NTSC);
        nat_vs_end = vpos_t'(`VS_END_NTSC);
        nat_max_h  = vpos_t'(`MAX_H_R56A);
        case (frame.chip)
            `CHIP6569R1, `CHIP6569R3: begin   // 504 x 312
                nat_ha_sta = hpos_t'(`HA_STA_PAL);
                nat_max_w  = hpos_t'(`MAX_W_PAL);
                nat_va_end = vpos_t'(`VA_END_PAL);
                nat_va_sta = vpos_t'(`VA_STA_PAL);
                nat_vs_sta = vpos_t'(`VS_STA_PAL);
                nat_vs_end = vpos_t'(`VS_END_PAL);
                nat_max_h  = vpos_t'(`MAX_H_PAL);
            end
            `CHIP6567R8: begin                 // 520 x 263
                nat_max_w = hpos_t'(`MAX_W_R8);
                nat_max_h = vpos_t'(`MAX_H_R8);
            end
            default: ;                         // r56a, 512 x 262
        endcase
    end

    assign ha_end = scale_h(hpos_t'(`HA_END), frame.native_x);
    assign hs_sta = scale_h(hpos_t'(`HS_STA), frame.native_x);
    assign hs_end = scale_h(hpos_t'(`HS_END), frame.native_x);
    assign ha_sta = scale_h(nat_ha_sta, frame.native_x);
    assign va_end = scale_v(nat_va_end, frame.native_y);
    assign va_sta = scale_v(nat_va_sta, frame.native_y);
    assign vs_sta = scale_v(nat_vs_sta, frame.native_y);
    assign vs_end = scale_v(nat_vs_end, frame.native_y);

    // doubled last index is 2*(max+1)-1
    assign max_w = frame.native_x ? nat_max_w : hpos_t'({nat_max_w, 1'b1});
    assign max_h = frame.native_y ? nat_max_h : vpos_t'({nat_max_h, 1'b1});

    // 2x2 every clock, one axis doubled on 1 and 3, native on 1 only
    always_comb begin
        case ({frame.native_x, frame.native_y})
            2'b00:   advance = 1'b1;
            2'b11:   advance = (phase == 2'b01);
            default: advance = phase[0];
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase       <= 2'b01;
            h_count     <= '0;
            v_count     <= '0;
            half_bright <= 1'b0;
        end else begin
            phase <= phase + 2'd1;
            if (advance) begin
                if (h_count < max_w) begin
                    h_count <= h_count + 1'b1;
                end else begin
                    h_count <= '0;
                    if (v_count < max_h) begin
                        v_count     <= v_count + 1'b1;
                        half_bright <= ~half_bright;   // every other output line dimmed
                    end else begin
                        v_count     <= '0;
                        half_bright <= 1'b0;           // frame starts on a bright line
                    end
                end
            end
            // park on the last line so the next wrap lands on line 0
            if (frame.frame_start) begin
                v_count <= max_h;
            end
        end
    end

    assign rd_addr = h_count;

    // vsync edges follow hs_sta / hs_end so the first and last lines are whole
    assign hsync_ah = (h_count >= hs_sta) && (h_count <= hs_end);
    assign vsync_ah = ((v_count == vs_sta && h_count >= hs_sta) || v_count > vs_sta)
                   && (v_count < vs_end || (v_count == vs_end && h_count < hs_end));
    assign csync_ah = hsync_ah || vsync_ah;

    assign hsync = enable_csync ? (csync_ah ~^ hpolarity) : (hsync_ah ~^ hpolarity);
    assign vsync = enable_csync ? 1'b0 : (vsync_ah ~^ vpolarity);

    // vertical blanking window, taken whole lines from ha_end
    assign vactive = ((v_count == va_end && h_count >= ha_end) || v_count > va_end)
                  && ((v_count == va_sta && h_count < ha_sta) || v_count < va_sta);

    // pal blanking wraps through 0, so its window is inverted
    assign active = !((h_count >= ha_end && h_count <= ha_sta)
                   || (frame.chip[0] ? !vactive : vactive));

endmodule

//--- line_buffer.sv
`timescale 1ns/1ps
`include "vga_defs.svh"

// double line buffer, one bank fills at native rate while the
// other is scanned out at the output rate
module line_buffer (
    input  logic               clk_dot4x,
    input  logic               rst,
    input  logic               swap,        // start of a new raster line
    input  vga_pkg::raster_x_t wr_addr,
    input  vga_pkg::color_t    wr_color,
    input  vga_pkg::hpos_t     rd_addr,     // output column
    output vga_pkg::color_t    pixel_color_out
);
    import vga_pkg::*;

    logic bank_sel;    // bank being written, the other one is read

    for (genvar b = 0; b < 2; b++) begin : g_bank
        (* ram_style = "block" *) color_t mem [`LINE_DEPTH];
        logic   we;
        hpos_t  addr;
        color_t dout;

        assign we   = (bank_sel == 1'(b));
        assign addr = we ? hpos_t'(wr_addr) : rd_addr; // single port, shared address

        always_ff @(posedge clk_dot4x) begin
            if (we) begin
                mem[addr] <= wr_color;
            end
            dout <= mem[addr];             // read data lags by one clock
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            bank_sel <= 1'b0;
        end else if (swap) begin
            bank_sel <= ~bank_sel;
        end
    end

    // second stage, picks the bank that is not being written
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_color_out <= '0;
        end else begin
            pixel_color_out <= bank_sel ? g_bank[0].dout : g_bank[1].dout;
        end
    end

endmodule

//--- raster_capture.sv
`timescale 1ns/1ps
`include "vga_defs.svh"

module raster_capture (
    input  logic               clk_dot4x,
    input  logic               rst,
    input  logic [3:0]         dot_rising,     // one-hot dot phase
    input  vga_pkg::raster_x_t raster_x,
    input  vga_pkg::raster_y_t raster_y,
    input  vga_pkg::color_t    pixel_color,
    input  logic               is_native_x_in,
    input  logic               is_native_y_in,
    input  vga_pkg::chip_t     chip,
    output vga_pkg::raster_x_t wr_addr,
    output vga_pkg::color_t    wr_color,
    output logic               swap,
    frame_if.capture           frame
);
    import vga_pkg::*;

    logic   at_origin;     // raster sits on column 0 of line 0
    logic   start_q;       // delayed so the mode below is settled
    logic   native_x_q;
    logic   native_y_q;
    chip_t  chip_q;

    // the origin lasts a whole dot, phase 1 picks one clock of it
    assign at_origin = dot_rising[1] && (raster_x == '0) && (raster_y == '0);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            start_q    <= 1'b0;
            native_x_q <= 1'b1;            // come up in native mode
            native_y_q <= 1'b1;
            chip_q     <= chip;
        end else begin
            start_q <= at_origin;
            if (at_origin) begin           // mode only changes on a frame boundary
                native_x_q <= is_native_x_in;
                native_y_q <= is_native_y_in;
                chip_q     <= chip;
            end
        end
    end

    assign frame.frame_start = start_q;    // one clock after the latch
    assign frame.native_x    = native_x_q;
    assign frame.native_y    = native_y_q;
    assign frame.chip        = chip_q;

    // pixels go straight into the line ram, raster_x is the address
    assign wr_addr  = raster_x;
    assign wr_color = pixel_color;

    // new raster line starts, flip the banks
    assign swap = dot_rising[1] && (raster_x == '0);

endmodule

//--- frame_if.sv
`timescale 1ns/1ps

// frame-level control from the capture side to the scan timing
interface frame_if;

    logic           frame_start; // one clock pulse, mode below already valid
    logic           native_x;    // 1 = native x, 0 = doubled
    logic           native_y;    // 1 = native y, 0 = doubled
    vga_pkg::chip_t chip;        // chip latched for this frame

    modport capture (
        output frame_start,
        output native_x,
        output native_y,
        output chip
    );

    modport timing (
        input frame_start,
        input native_x,
        input native_y,
        input chip
    );

endinterface

//--- vga_pkg.sv
`include "vga_defs.svh"

package vga_pkg;

    // color index as produced by the video chip
    typedef logic [`COLOR_W-1:0] color_t;

    // output column, wide enough for a doubled line
    typedef logic [`HPOS_W-1:0] hpos_t;

    // output line, wide enough for a doubled frame
    typedef logic [`VPOS_W-1:0] vpos_t;

    // native raster column
    typedef logic [`RASTER_X_W-1:0] raster_x_t;

    // native raster row
    typedef logic [`RASTER_Y_W-1:0] raster_y_t;

    // chip code, see the CHIP* macros
    typedef logic [`CHIP_W-1:0] chip_t;

endpackage

//--- vga_defs.svh
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

// widths
`define COLOR_W      4     // color index width
`define HPOS_W       11    // output horizontal count width
`define VPOS_W       10    // output vertical count width
`define RASTER_X_W   10    // native raster x width
`define RASTER_Y_W   9     // native raster y width
`define CHIP_W       2     // chip code width
`define LINE_DEPTH   2048  // line ram depth, covers widest doubled line

// chip codes, bit 0 set means a pal part
`define CHIP6567R8   2'd0
`define CHIP6569R3   2'd1
`define CHIP6567R56A 2'd2
`define CHIP6569R1   2'd3

// horizontal boundaries in native columns, same for every chip
`define HA_END       0     // active ends
`define HS_STA       10    // front porch done, sync starts
`define HS_END       70    // sync ends
`define HA_STA_PAL   90    // pal back porch done
`define HA_STA_NTSC  80    // ntsc back porch done

// pal vertical, blanking wraps through line 0 so the active range is inverted
`define VA_END_PAL   20    // really the active start
`define VA_STA_PAL   284   // really the active end
`define VS_STA_PAL   289   // vsync starts
`define VS_END_PAL   291   // vsync ends

// ntsc vertical
`define VA_END_NTSC  11    // active ends
`define VS_STA_NTSC  19    // vsync starts
`define VS_END_NTSC  22    // vsync ends
`define VA_STA_NTSC  24    // active starts

// last native column
`define MAX_W_PAL    503
`define MAX_W_R8     519
`define MAX_W_R56A   511

// last native line
`define MAX_H_PAL    311
`define MAX_H_R8     262
`define MAX_H_R56A   261

`endif
